// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exu_top -f sources.f -o sim_exu

out=$(./obj_dir/sim_exu 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
	exit 0
else
	exit 1
fi

// File: rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  wire rv_isa_pkg::alu_op_e op,
	input  wire rv_isa_pkg::xword_t  src1,
	input  wire rv_isa_pkg::xword_t  src2,
	output rv_isa_pkg::xword_t       result
);
	import rv_isa_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	logic eq;

	// rv32 uses only the low five bits as shift amount
	assign shamt = src2[4:0];
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;
	assign eq = (src1 == src2);

	always_comb begin
		unique case (op)
			ALU_ADD:    result = src1 + src2;
			ALU_SUB:    result = src1 - src2;
			ALU_AND:    result = src1 & src2;
			ALU_OR:     result = src1 | src2;
			ALU_XOR:    result = src1 ^ src2;
			ALU_SLL:    result = src1 << shamt;
			ALU_SRL:    result = src1 >> shamt;
			ALU_SRA:    result = xword_t'($signed(src1) >>> shamt);
			ALU_SLT:    result = xword_t'(lt_s);
			ALU_SLTU:   result = xword_t'(lt_u);
			// branch compares
			ALU_EQ:     result = xword_t'(eq);
			ALU_NE:     result = xword_t'(!eq);
			ALU_LT:     result = xword_t'(lt_s);
			ALU_GE:     result = xword_t'(!lt_s);
			ALU_LTU:    result = xword_t'(lt_u);
			ALU_GEU:    result = xword_t'(!lt_u);
			// lui style, operand already formed by decode
			ALU_PASS_B: result = src2;
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rv_bus_pkg.sv
`include "rv_exu_config.svh"
`default_nettype none

package rv_bus_pkg;

	typedef logic [`RV_XLEN-1:0] bus_addr_t;
	typedef logic [`RV_XLEN-1:0] bus_data_t;
	typedef logic [`RV_XLEN/8-1:0] bus_strb_t;
	typedef logic [1:0] bus_resp_t;

	localparam bus_resp_t RESP_OKAY = 2'b00;

	// read side: ar then r
	typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

	// write side: aw, w, then b
	typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

endpackage

`default_nettype wire

// File: rv_dsram.sv
`include "rv_exu_config.svh"
`timescale 1ns/1ps
`default_nettype none

module rv_dsram (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire rv_bus_pkg::bus_addr_t awaddr,
	input  wire logic                  awvalid,
	output logic                       awready,
	input  wire rv_bus_pkg::bus_data_t wdata,
	input  wire rv_bus_pkg::bus_strb_t wstrb,
	input  wire logic                  wvalid,
	output logic                       wready,
	output rv_bus_pkg::bus_resp_t      bresp,
	output logic                       bvalid,
	input  wire logic                  bready,
	input  wire rv_bus_pkg::bus_addr_t araddr,
	input  wire logic                  arvalid,
	output logic                       arready,
	output rv_bus_pkg::bus_data_t      rdata,
	output rv_bus_pkg::bus_resp_t      rresp,
	output logic                       rvalid,
	input  wire logic                  rready
);
	import rv_bus_pkg::*;

	localparam int IDX_W = $clog2(`RV_DSRAM_WORDS);

	bus_data_t mem [`RV_DSRAM_WORDS];
	logic [IDX_W-1:0] waddr_q;
	logic aw_pend;

	// readies pulse one cycle after the matching valid shows up
	always_ff @(posedge clk) begin
		if (rst) begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			aw_pend <= 1'b0;
		end else begin
			awready <= awvalid && !awready && !aw_pend;
			wready <= wvalid && !wready && aw_pend;
			arready <= arvalid && !arready && !rvalid;
			if (awvalid && awready)
				aw_pend <= 1'b1;
			else if (wvalid && wready)
				aw_pend <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (wvalid && wready)
				bvalid <= 1'b1;
			if (rvalid && rready)
				rvalid <= 1'b0;
			else if (arvalid && arready)
				rvalid <= 1'b1;
		end
	end

	// word index of the pending write
	always_ff @(posedge clk) begin
		if (awvalid && awready)
			waddr_q <= awaddr[IDX_W+1:2];
	end

	always_ff @(posedge clk) begin
		if (wvalid && wready) begin
			for (int i = 0; i < $bits(bus_strb_t); i++) begin
				if (wstrb[i])
					mem[waddr_q][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
		if (arvalid && arready)
			rdata <= mem[araddr[IDX_W+1:2]];
	end

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

endmodule

`default_nettype wire

// File: rv_exu.sv
`include "rv_exu_config.svh"
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    id_valid,
	input  wire rv_isa_pkg::xword_t      id_pc,
	input  wire rv_isa_pkg::alu_op_e     id_alu_op,
	input  wire rv_isa_pkg::xword_t      id_src1,
	input  wire rv_isa_pkg::xword_t      id_src2,
	input  wire rv_isa_pkg::reg_idx_t    id_rd,
	input  wire logic                    id_wb_en,
	input  wire rv_isa_pkg::load_kind_e  id_load_kind,
	input  wire rv_isa_pkg::store_kind_e id_store_kind,
	input  wire rv_isa_pkg::xword_t      id_store_data,
	input  wire rv_isa_pkg::jump_kind_e  id_jump_kind,
	input  wire logic                    id_branch,
	input  wire rv_isa_pkg::xword_t      id_branch_target,
	input  wire rv_isa_pkg::csr_op_e     id_csr_op,
	input  wire rv_isa_pkg::csr_addr_t   id_csr_idx,
	input  wire logic                    id_csr_redirect,
	input  wire rv_isa_pkg::xword_t      id_csr_redirect_pc,
	output logic                         exu_allowin,
	output logic                         commit_valid,
	output rv_isa_pkg::xword_t           commit_pc,
	output logic                         rf_wen,
	output rv_isa_pkg::reg_idx_t         rf_waddr,
	output rv_isa_pkg::xword_t           rf_wdata,
	output logic                         redirect_taken,
	output rv_isa_pkg::xword_t           redirect_pc,
	output logic                         csr_wen,
	output rv_isa_pkg::csr_addr_t        csr_waddr,
	output rv_isa_pkg::xword_t           csr_wdata,
	output logic                         csr_wen2,
	output rv_isa_pkg::csr_addr_t        csr_waddr2,
	output rv_isa_pkg::xword_t           csr_wdata2,
	output rv_bus_pkg::bus_addr_t        awaddr,
	output logic                         awvalid,
	input  wire logic                    awready,
	output rv_bus_pkg::bus_data_t        wdata,
	output rv_bus_pkg::bus_strb_t        wstrb,
	output logic                         wvalid,
	input  wire logic                    wready,
	input  wire rv_bus_pkg::bus_resp_t   bresp,
	input  wire logic                    bvalid,
	output logic                         bready,
	output rv_bus_pkg::bus_addr_t        araddr,
	output logic                         arvalid,
	input  wire logic                    arready,
	input  wire rv_bus_pkg::bus_data_t   rdata,
	input  wire rv_bus_pkg::bus_resp_t   rresp,
	input  wire logic                    rvalid,
	output logic                         rready
);
	import rv_isa_pkg::*;

	logic exu_valid;
	logic accept;
	logic mem_done;
	logic cond_taken;
	xword_t alu_result;
	xword_t load_data;

	// held instruction
	xword_t pc_q;
	alu_op_e alu_op_q;
	xword_t src1_q;
	xword_t src2_q;
	reg_idx_t rd_q;
	logic wb_en_q;
	load_kind_e load_kind_q;
	store_kind_e store_kind_q;
	xword_t store_data_q;
	jump_kind_e jump_kind_q;
	logic branch_q;
	xword_t branch_target_q;
	csr_op_e csr_op_q;
	csr_addr_t csr_idx_q;
	logic csr_redirect_q;
	xword_t csr_redirect_pc_q;

	// ready-go comes from the lsu, always set for non-memory ops
	assign exu_allowin = !exu_valid || mem_done;
	assign commit_valid = exu_valid && mem_done;
	assign accept = exu_allowin && id_valid;

	always_ff @(posedge clk) begin
		if (rst)
			exu_valid <= 1'b0;
		else if (exu_allowin)
			exu_valid <= id_valid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en_q <= 1'b0;
			load_kind_q <= LD_NONE;
			store_kind_q <= ST_NONE;
			jump_kind_q <= JMP_NONE;
			branch_q <= 1'b0;
			csr_op_q <= CSR_NONE;
			csr_redirect_q <= 1'b0;
		end else if (accept) begin
			wb_en_q <= id_wb_en;
			load_kind_q <= id_load_kind;
			store_kind_q <= id_store_kind;
			jump_kind_q <= id_jump_kind;
			branch_q <= id_branch;
			csr_op_q <= id_csr_op;
			csr_redirect_q <= id_csr_redirect;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q <= id_pc;
			alu_op_q <= id_alu_op;
			src1_q <= id_src1;
			src2_q <= id_src2;
			rd_q <= id_rd;
			store_data_q <= id_store_data;
			branch_target_q <= id_branch_target;
			csr_idx_q <= id_csr_idx;
			csr_redirect_pc_q <= id_csr_redirect_pc;
		end
	end

	rv_alu u_alu (
		.op(alu_op_q),
		.src1(src1_q),
		.src2(src2_q),
		.result(alu_result)
	);

	// memory address is the alu sum of base and offset
	rv_lsu u_lsu (
		.clk,
		.rst,
		.req(exu_valid),
		.load_kind(load_kind_q),
		.store_kind(store_kind_q),
		.addr(alu_result),
		.store_data(store_data_q),
		.mem_done,
		.load_data,
		.awaddr,
		.awvalid,
		.awready,
		.wdata,
		.wstrb,
		.wvalid,
		.wready,
		.bresp,
		.bvalid,
		.bready,
		.araddr,
		.arvalid,
		.arready,
		.rdata,
		.rresp,
		.rvalid,
		.rready
	);

	assign commit_pc = pc_q;

	assign cond_taken = branch_q && alu_result[0];

	always_comb begin
		if (csr_redirect_q)
			redirect_pc = csr_redirect_pc_q;
		else if (jump_kind_q == JMP_JAL)
			redirect_pc = alu_result;
		else if (jump_kind_q == JMP_JALR)
			redirect_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
		else
			redirect_pc = branch_target_q;
	end

	assign redirect_taken = commit_valid
		&& (cond_taken || (jump_kind_q != JMP_NONE) || csr_redirect_q);

	// link address, load data, old csr value or alu result
	always_comb begin
		if (jump_kind_q != JMP_NONE)
			rf_wdata = pc_q + xword_t'(4);
		else if (load_kind_q != LD_NONE)
			rf_wdata = load_data;
		else if ((csr_op_q == CSR_RW) || (csr_op_q == CSR_RS))
			rf_wdata = src2_q;
		else
			rf_wdata = alu_result;
	end

	assign rf_wen = commit_valid && wb_en_q;
	assign rf_waddr = rd_q;

	// csrrs gets csr | rs1 from the alu
	always_comb begin
		unique case (csr_op_q)
			CSR_RW:  csr_wdata = src1_q;
			CSR_RS:  csr_wdata = alu_result;
			default: csr_wdata = pc_q;
		endcase
	end

	assign csr_wen = commit_valid && (csr_op_q != CSR_NONE);
	assign csr_waddr = (csr_op_q == CSR_ECALL) ? csr_addr_t'(`RV_CSR_MEPC) : csr_idx_q;

	// second port only used by ecall
	assign csr_wen2 = commit_valid && (csr_op_q == CSR_ECALL);
	assign csr_waddr2 = csr_addr_t'(`RV_CSR_MCAUSE);
	assign csr_wdata2 = xword_t'(`RV_ECALL_CAUSE);

endmodule

`default_nettype wire

// File: rv_exu_config.svh
`ifndef RV_EXU_CONFIG_SVH
`define RV_EXU_CONFIG_SVH

// datapath widths
`define RV_XLEN 32
`define RV_REG_W 5

// data sram depth in words
`define RV_DSRAM_WORDS 256

// machine trap csrs
`define RV_CSR_MEPC 12'h341
`define RV_CSR_MCAUSE 12'h342

// environment call from m-mode
`define RV_ECALL_CAUSE 11

`endif

// File: rv_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exu_top (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    id_valid,
	input  wire rv_isa_pkg::xword_t      id_pc,
	input  wire rv_isa_pkg::alu_op_e     id_alu_op,
	input  wire rv_isa_pkg::xword_t      id_src1,
	input  wire rv_isa_pkg::xword_t      id_src2,
	input  wire rv_isa_pkg::reg_idx_t    id_rd,
	input  wire logic                    id_wb_en,
	input  wire rv_isa_pkg::load_kind_e  id_load_kind,
	input  wire rv_isa_pkg::store_kind_e id_store_kind,
	input  wire rv_isa_pkg::xword_t      id_store_data,
	input  wire rv_isa_pkg::jump_kind_e  id_jump_kind,
	input  wire logic                    id_branch,
	input  wire rv_isa_pkg::xword_t      id_branch_target,
	input  wire rv_isa_pkg::csr_op_e     id_csr_op,
	input  wire rv_isa_pkg::csr_addr_t   id_csr_idx,
	input  wire logic                    id_csr_redirect,
	input  wire rv_isa_pkg::xword_t      id_csr_redirect_pc,
	output logic                         exu_allowin,
	output logic                         commit_valid,
	output rv_isa_pkg::xword_t           commit_pc,
	output logic                         rf_wen,
	output rv_isa_pkg::reg_idx_t         rf_waddr,
	output rv_isa_pkg::xword_t           rf_wdata,
	output logic                         redirect_taken,
	output rv_isa_pkg::xword_t           redirect_pc,
	output logic                         csr_wen,
	output rv_isa_pkg::csr_addr_t        csr_waddr,
	output rv_isa_pkg::xword_t           csr_wdata,
	output logic                         csr_wen2,
	output rv_isa_pkg::csr_addr_t        csr_waddr2,
	output rv_isa_pkg::xword_t           csr_wdata2
);
	import rv_bus_pkg::*;

	// data bus between the lsu and the sram
	bus_addr_t awaddr;
	logic awvalid;
	logic awready;
	bus_data_t wdata;
	bus_strb_t wstrb;
	logic wvalid;
	logic wready;
	bus_resp_t bresp;
	logic bvalid;
	logic bready;
	bus_addr_t araddr;
	logic arvalid;
	logic arready;
	bus_data_t rdata;
	bus_resp_t rresp;
	logic rvalid;
	logic rready;

	// port names match one to one
	rv_exu u_exu (.*);

	rv_dsram u_dsram (.*);

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`include "rv_exu_config.svh"
`default_nettype none

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0] xword_t;
	typedef logic [`RV_REG_W-1:0] reg_idx_t;
	typedef logic [11:0] csr_addr_t;

	// compare ops leave their flag in bit 0
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {LD_NONE, LD_LW, LD_LH, LD_LHU, LD_LB, LD_LBU} load_kind_e;

	typedef enum logic [1:0] {ST_NONE, ST_SW, ST_SH, ST_SB} store_kind_e;

	typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR} jump_kind_e;

	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_ECALL} csr_op_e;

endpackage

`default_nettype wire

// File: rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    req,
	input  wire rv_isa_pkg::load_kind_e  load_kind,
	input  wire rv_isa_pkg::store_kind_e store_kind,
	input  wire rv_isa_pkg::xword_t      addr,
	input  wire rv_isa_pkg::xword_t      store_data,
	output logic                         mem_done,
	output rv_isa_pkg::xword_t           load_data,
	output rv_bus_pkg::bus_addr_t        awaddr,
	output logic                         awvalid,
	input  wire logic                    awready,
	output rv_bus_pkg::bus_data_t        wdata,
	output rv_bus_pkg::bus_strb_t        wstrb,
	output logic                         wvalid,
	input  wire logic                    wready,
	input  wire rv_bus_pkg::bus_resp_t   bresp,
	input  wire logic                    bvalid,
	output logic                         bready,
	output rv_bus_pkg::bus_addr_t        araddr,
	output logic                         arvalid,
	input  wire logic                    arready,
	input  wire rv_bus_pkg::bus_data_t   rdata,
	input  wire rv_bus_pkg::bus_resp_t   rresp,
	input  wire logic                    rvalid,
	output logic                         rready
);
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	rd_state_e rd_state;
	rd_state_e rd_next;
	wr_state_e wr_state;
	wr_state_e wr_next;
	logic is_load;
	logic is_store;
	logic done_q;
	bus_resp_t resp_q;
	bus_data_t rdata_q;
	xword_t lane_data;
	xword_t ext_data;

	assign is_load = (load_kind != LD_NONE);
	assign is_store = (store_kind != ST_NONE);

	// done_q blocks a second access for the same held instruction
	always_comb begin
		rd_next = rd_state;
		unique case (rd_state)
			RD_IDLE: begin
				if (req && is_load && !done_q)
					rd_next = RD_ADDR;
			end
			RD_ADDR: begin
				if (arready)
					rd_next = RD_DATA;
			end
			RD_DATA: begin
				if (rvalid)
					rd_next = RD_IDLE;
			end
			default: rd_next = RD_IDLE;
		endcase
	end

	always_comb begin
		wr_next = wr_state;
		unique case (wr_state)
			WR_IDLE: begin
				if (req && is_store && !done_q)
					wr_next = WR_ADDR;
			end
			WR_ADDR: begin
				if (awready)
					wr_next = WR_DATA;
			end
			WR_DATA: begin
				if (wready)
					wr_next = WR_RESP;
			end
			WR_RESP: begin
				if (bvalid)
					wr_next = WR_IDLE;
			end
			default: wr_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= RD_IDLE;
			wr_state <= WR_IDLE;
			done_q <= 1'b0;
		end else begin
			rd_state <= rd_next;
			wr_state <= wr_next;
			done_q <= (rvalid && rready) || (bvalid && bready);
		end
	end

	always_ff @(posedge clk) begin
		if (rvalid && rready) begin
			rdata_q <= rdata;
			resp_q <= rresp;
		end else if (bvalid && bready) begin
			resp_q <= bresp;
		end
	end

	// valids and readies come straight from the state
	assign arvalid = (rd_state == RD_ADDR);
	assign rready = (rd_state == RD_DATA);
	assign awvalid = (wr_state == WR_ADDR);
	assign wvalid = (wr_state == WR_DATA);
	assign bready = (wr_state == WR_RESP);

	assign araddr = {addr[31:2], 2'b00};
	assign awaddr = {addr[31:2], 2'b00};

	// replicate the store data so any lane can be picked by the strobe
	always_comb begin
		unique case (store_kind)
			ST_SH: begin
				wdata = {2{store_data[15:0]}};
				wstrb = addr[1] ? 4'b1100 : 4'b0011;
			end
			ST_SB: begin
				wdata = {4{store_data[7:0]}};
				wstrb = 4'b0001 << addr[1:0];
			end
			default: begin
				wdata = store_data;
				wstrb = 4'b1111;
			end
		endcase
	end

	assign lane_data = rdata_q >> {addr[1:0], 3'b000};

	always_comb begin
		unique case (load_kind)
			LD_LH:   ext_data = {{16{lane_data[15]}}, lane_data[15:0]};
			LD_LHU:  ext_data = {16'b0, lane_data[15:0]};
			LD_LB:   ext_data = {{24{lane_data[7]}}, lane_data[7:0]};
			LD_LBU:  ext_data = {24'b0, lane_data[7:0]};
			default: ext_data = rdata_q;
		endcase
	end

	// an errored access returns zero
	assign load_data = (resp_q == RESP_OKAY) ? ext_data : '0;

	assign mem_done = (is_load || is_store) ? done_q : 1'b1;

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_alu.sv
rv_lsu.sv
rv_exu.sv
rv_dsram.sv
rv_exu_top.sv
tb_exu_properties.sv
tb_exu_top.sv

// File: tb_exu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_properties (
	input wire logic clk,
	input wire logic rst,
	input wire logic awvalid,
	input wire logic awready,
	input wire logic wvalid,
	input wire logic wready,
	input wire logic bvalid,
	input wire logic bready,
	input wire logic arvalid,
	input wire logic arready,
	input wire logic rvalid,
	input wire logic rready,
	input wire logic commit_valid,
	input wire logic rf_wen,
	input wire logic exu_allowin
);

	// a valid may only drop after its transfer
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before wready");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// register writes only at commit
	wen_qualified: assert property (@(posedge clk) disable iff (rst)
		rf_wen |-> commit_valid)
		else $error("rf_wen high without commit_valid");

	// stage is empty right after reset
	allowin_after_reset: assert property (@(posedge clk)
		$past(rst) && !rst |-> exu_allowin)
		else $error("exu_allowin low after reset");

endmodule

bind rv_exu_top tb_exu_properties props (
	.clk(clk),
	.rst(rst),
	.awvalid(awvalid),
	.awready(awready),
	.wvalid(wvalid),
	.wready(wready),
	.bvalid(bvalid),
	.bready(bready),
	.arvalid(arvalid),
	.arready(arready),
	.rvalid(rvalid),
	.rready(rready),
	.commit_valid(commit_valid),
	.rf_wen(rf_wen),
	.exu_allowin(exu_allowin)
);

`default_nettype wire

// File: tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;
	import rv_isa_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam int N_ALU = 40;
	localparam int N_STORE = 24;
	localparam int N_LOAD = 30;
	localparam int N_BRANCH = 20;
	localparam int N_JUMP = 10;
	localparam int N_CSR = 3;
	localparam int N_MIX = 40;
	localparam int MEM_BASE = 'h100;
	localparam int MEM_WORDS = 16;
	localparam int N_TOTAL = N_ALU + MEM_WORDS + N_STORE + N_LOAD + N_BRANCH
		+ 2 * N_JUMP + 3 * N_CSR + N_MIX;

	// machine trap csrs and the ecall cause code
	localparam csr_addr_t MEPC_ADDR = 12'h341;
	localparam csr_addr_t MCAUSE_ADDR = 12'h342;
	localparam xword_t ECALL_CAUSE = 32'd11;

	typedef struct packed {
		xword_t pc;
		logic rf_wen;
		reg_idx_t rd;
		xword_t rf_wdata;
		logic redir;
		xword_t redir_pc;
		logic csr_wen;
		csr_addr_t csr_waddr;
		xword_t csr_wdata;
		logic csr_wen2;
	} expect_t;

	logic clk;
	logic rst;
	logic id_valid;
	xword_t id_pc;
	alu_op_e id_alu_op;
	xword_t id_src1;
	xword_t id_src2;
	reg_idx_t id_rd;
	logic id_wb_en;
	load_kind_e id_load_kind;
	store_kind_e id_store_kind;
	xword_t id_store_data;
	jump_kind_e id_jump_kind;
	logic id_branch;
	xword_t id_branch_target;
	csr_op_e id_csr_op;
	csr_addr_t id_csr_idx;
	logic id_csr_redirect;
	xword_t id_csr_redirect_pc;
	logic exu_allowin;
	logic commit_valid;
	xword_t commit_pc;
	logic rf_wen;
	reg_idx_t rf_waddr;
	xword_t rf_wdata;
	logic redirect_taken;
	xword_t redirect_pc;
	logic csr_wen;
	csr_addr_t csr_waddr;
	xword_t csr_wdata;
	logic csr_wen2;
	csr_addr_t csr_waddr2;
	xword_t csr_wdata2;

	expect_t exp_q[$];
	logic [7:0] shadow [0:1023];
	xword_t pc_ctr;
	int commit_count;
	logic fast_pending;
	logic mem_pending;

	rv_exu_top uut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task abort_run;
		$display("Regression failed");
		$fatal(1);
	endtask

	task check_value(input string name, input xword_t got, input xword_t exp);
		assert (got === exp) else begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			abort_run;
		end
	endtask

	// reference behavior of each alu op
	function automatic xword_t alu_model(alu_op_e op, xword_t a, xword_t b);
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $signed(a) >>> b[4:0];
			ALU_SLT, ALU_LT: return {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU, ALU_LTU: return {31'b0, a < b};
			ALU_EQ:   return {31'b0, a == b};
			ALU_NE:   return {31'b0, a != b};
			ALU_GE:   return {31'b0, $signed(a) >= $signed(b)};
			ALU_GEU:  return {31'b0, a >= b};
			default:  return b;
		endcase
	endfunction

	function automatic xword_t load_model(load_kind_e k, int unsigned a);
		int unsigned wa;
		logic [15:0] h;
		logic [7:0] b;
		wa = a & ~32'd3;
		h = {shadow[a + 1], shadow[a]};
		b = shadow[a];
		case (k)
			LD_LH:   return {{16{h[15]}}, h};
			LD_LHU:  return {16'b0, h};
			LD_LB:   return {{24{b[7]}}, b};
			LD_LBU:  return {24'b0, b};
			default: return {shadow[wa + 3], shadow[wa + 2], shadow[wa + 1], shadow[wa]};
		endcase
	endfunction

	function automatic int unsigned pick_addr(int unsigned align);
		return MEM_BASE + ($urandom_range(0, MEM_WORDS * 4 - 1) & ~(align - 1));
	endfunction

	function automatic expect_t blank_expect(xword_t pc);
		expect_t e;
		e = '0;
		e.pc = pc;
		return e;
	endfunction

	// defaults for a fresh bundle that the caller then overrides
	task start_bundle;
		id_pc <= pc_ctr;
		id_alu_op <= ALU_ADD;
		id_src1 <= '0;
		id_src2 <= '0;
		id_rd <= '0;
		id_wb_en <= 1'b0;
		id_load_kind <= LD_NONE;
		id_store_kind <= ST_NONE;
		id_store_data <= '0;
		id_jump_kind <= JMP_NONE;
		id_branch <= 1'b0;
		id_branch_target <= '0;
		id_csr_op <= CSR_NONE;
		id_csr_idx <= '0;
		id_csr_redirect <= 1'b0;
		id_csr_redirect_pc <= '0;
	endtask

	// returns on the accepting edge
	task issue(input expect_t e);
		id_valid <= 1'b1;
		exp_q.push_back(e);
		pc_ctr = pc_ctr + 4;
		@(posedge clk);
		while (!exu_allowin)
			@(posedge clk);
	endtask

	task idle_cycle;
		id_valid <= 1'b0;
		@(posedge clk);
	endtask

	task alu_instr;
		alu_op_e op;
		xword_t a;
		xword_t b;
		reg_idx_t rd;
		expect_t e;
		op = alu_op_e'($urandom_range(0, 16));
		a = $urandom;
		b = $urandom;
		rd = reg_idx_t'($urandom);
		e = blank_expect(pc_ctr);
		e.rf_wen = 1'b1;
		e.rd = rd;
		e.rf_wdata = alu_model(op, a, b);
		start_bundle;
		id_alu_op <= op;
		id_src1 <= a;
		id_src2 <= b;
		id_rd <= rd;
		id_wb_en <= 1'b1;
		issue(e);
	endtask

	task store_instr(input store_kind_e k, input int unsigned a, input xword_t d);
		int unsigned off;
		off = $urandom_range(0, 64);
		if (k == ST_SW) begin
			for (int i = 0; i < 4; i++)
				shadow[a + i] = d[i*8 +: 8];
		end else if (k == ST_SH) begin
			shadow[a] = d[7:0];
			shadow[a + 1] = d[15:8];
		end else begin
			shadow[a] = d[7:0];
		end
		start_bundle;
		id_src1 <= xword_t'(a - off);
		id_src2 <= xword_t'(off);
		id_store_kind <= k;
		id_store_data <= d;
		issue(blank_expect(pc_ctr));
	endtask

	task random_store;
		store_kind_e k;
		k = store_kind_e'($urandom_range(1, 3));
		store_instr(k, pick_addr(k == ST_SW ? 4 : (k == ST_SH ? 2 : 1)), $urandom);
	endtask

	task load_instr;
		load_kind_e k;
		int unsigned a;
		int unsigned off;
		reg_idx_t rd;
		expect_t e;
		k = load_kind_e'($urandom_range(1, 5));
		a = pick_addr(k == LD_LW ? 4 : ((k == LD_LH || k == LD_LHU) ? 2 : 1));
		off = $urandom_range(0, 64);
		rd = reg_idx_t'($urandom);
		e = blank_expect(pc_ctr);
		e.rf_wen = 1'b1;
		e.rd = rd;
		e.rf_wdata = load_model(k, a);
		start_bundle;
		id_src1 <= xword_t'(a - off);
		id_src2 <= xword_t'(off);
		id_rd <= rd;
		id_wb_en <= 1'b1;
		id_load_kind <= k;
		issue(e);
	endtask

	task branch_instr;
		alu_op_e op;
		xword_t a;
		xword_t b;
		xword_t tgt;
		xword_t cmp;
		expect_t e;
		op = alu_op_e'(int'(ALU_EQ) + $urandom_range(0, 5));
		a = $urandom;
		b = ($urandom_range(0, 3) == 0) ? a : $urandom;
		tgt = $urandom & ~32'd3;
		cmp = alu_model(op, a, b);
		e = blank_expect(pc_ctr);
		e.redir = cmp[0];
		e.redir_pc = tgt;
		start_bundle;
		id_alu_op <= op;
		id_src1 <= a;
		id_src2 <= b;
		id_branch <= 1'b1;
		id_branch_target <= tgt;
		issue(e);
	endtask

	task jump_instr(input jump_kind_e k);
		xword_t a;
		xword_t b;
		reg_idx_t rd;
		expect_t e;
		a = (k == JMP_JAL) ? pc_ctr : $urandom;
		b = (k == JMP_JAL) ? ($urandom & ~32'd1) : $urandom_range(0, 2047);
		rd = reg_idx_t'($urandom);
		e = blank_expect(pc_ctr);
		e.rf_wen = 1'b1;
		e.rd = rd;
		e.rf_wdata = pc_ctr + 4;
		e.redir = 1'b1;
		e.redir_pc = (k == JMP_JAL) ? a + b : (a + b) & ~32'd1;
		start_bundle;
		id_src1 <= a;
		id_src2 <= b;
		id_rd <= rd;
		id_wb_en <= 1'b1;
		id_jump_kind <= k;
		issue(e);
	endtask

	task csr_instr(input csr_op_e op);
		xword_t a;
		xword_t b;
		xword_t rpc;
		csr_addr_t idx;
		reg_idx_t rd;
		expect_t e;
		a = $urandom;
		b = $urandom;
		rpc = $urandom & ~32'd3;
		idx = csr_addr_t'($urandom);
		rd = reg_idx_t'($urandom);
		e = blank_expect(pc_ctr);
		e.csr_wen = 1'b1;
		start_bundle;
		id_csr_op <= op;
		if (op == CSR_ECALL) begin
			e.csr_waddr = MEPC_ADDR;
			e.csr_wdata = pc_ctr;
			e.csr_wen2 = 1'b1;
			e.redir = 1'b1;
			e.redir_pc = rpc;
			id_csr_redirect <= 1'b1;
			id_csr_redirect_pc <= rpc;
		end else begin
			// old csr value arrives on src2
			e.rf_wen = 1'b1;
			e.rd = rd;
			e.rf_wdata = b;
			e.csr_waddr = idx;
			e.csr_wdata = (op == CSR_RW) ? a : (a | b);
			id_alu_op <= (op == CSR_RW) ? ALU_ADD : ALU_OR;
			id_src1 <= a;
			id_src2 <= b;
			id_rd <= rd;
			id_wb_en <= 1'b1;
			id_csr_idx <= idx;
		end
		issue(e);
	endtask

	// compare each commit with the oldest expected entry
	always @(posedge clk) begin
		expect_t e;
		if (!rst) begin
			if (fast_pending) begin
				assert (commit_valid) else begin
					$display("instruction did not commit in the cycle after acceptance");
					abort_run;
				end
			end
			if (mem_pending && !commit_valid) begin
				assert (!exu_allowin) else begin
					$display("exu_allowin went high while a memory access was in flight");
					abort_run;
				end
			end
			if (commit_valid) begin
				if (exp_q.size() == 0) begin
					$display("commit seen with no instruction outstanding");
					abort_run;
				end else begin
					e = exp_q.pop_front();
					check_value("commit_pc", commit_pc, e.pc);
					check_value("rf_wen", xword_t'(rf_wen), xword_t'(e.rf_wen));
					if (e.rf_wen) begin
						check_value("rf_waddr", xword_t'(rf_waddr), xword_t'(e.rd));
						check_value("rf_wdata", rf_wdata, e.rf_wdata);
					end
					check_value("redirect_taken", xword_t'(redirect_taken), xword_t'(e.redir));
					if (e.redir)
						check_value("redirect_pc", redirect_pc, e.redir_pc);
					check_value("csr_wen", xword_t'(csr_wen), xword_t'(e.csr_wen));
					if (e.csr_wen) begin
						check_value("csr_waddr", xword_t'(csr_waddr), xword_t'(e.csr_waddr));
						check_value("csr_wdata", csr_wdata, e.csr_wdata);
					end
					check_value("csr_wen2", xword_t'(csr_wen2), xword_t'(e.csr_wen2));
					if (e.csr_wen2) begin
						check_value("csr_waddr2", xword_t'(csr_waddr2), xword_t'(MCAUSE_ADDR));
						check_value("csr_wdata2", csr_wdata2, ECALL_CAUSE);
					end
					commit_count = commit_count + 1;
				end
			end
			fast_pending = 1'b0;
			mem_pending = mem_pending && !commit_valid;
			if (id_valid && exu_allowin) begin
				if (id_load_kind != LD_NONE || id_store_kind != ST_NONE)
					mem_pending = 1'b1;
				else
					fast_pending = 1'b1;
			end
		end
	end

	initial begin
		#(longint'(RST_CYCLES + N_TOTAL * 12) * CLK_PERIOD);
		$display("watchdog expired before all instructions committed");
		abort_run;
	end

	initial begin
		void'($urandom(47));
		clk = 1'b0;
		rst = 1'b1;
		id_valid = 1'b0;
		id_pc = '0;
		id_alu_op = ALU_ADD;
		id_src1 = '0;
		id_src2 = '0;
		id_rd = '0;
		id_wb_en = 1'b0;
		id_load_kind = LD_NONE;
		id_store_kind = ST_NONE;
		id_store_data = '0;
		id_jump_kind = JMP_NONE;
		id_branch = 1'b0;
		id_branch_target = '0;
		id_csr_op = CSR_NONE;
		id_csr_idx = '0;
		id_csr_redirect = 1'b0;
		id_csr_redirect_pc = '0;
		pc_ctr = 32'h1000;
		commit_count = 0;
		fast_pending = 1'b0;
		mem_pending = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < N_ALU; i++) begin
			alu_instr;
			idle_cycle;
		end
		// fill the test region so every load sees known data
		for (int w = 0; w < MEM_WORDS; w++)
			store_instr(ST_SW, MEM_BASE + 4 * w, $urandom);
		for (int i = 0; i < N_STORE; i++)
			random_store;
		for (int i = 0; i < N_LOAD; i++)
			load_instr;
		idle_cycle;
		for (int i = 0; i < N_BRANCH; i++) begin
			branch_instr;
			idle_cycle;
		end
		for (int i = 0; i < N_JUMP; i++) begin
			jump_instr(JMP_JAL);
			jump_instr(JMP_JALR);
		end
		for (int i = 0; i < N_CSR; i++) begin
			csr_instr(CSR_RW);
			csr_instr(CSR_RS);
			csr_instr(CSR_ECALL);
		end

		// back to back with id_valid held high
		for (int i = 0; i < N_MIX; i++) begin
			case ($urandom_range(0, 3))
				0: alu_instr;
				1: random_store;
				2: load_instr;
				default: branch_instr;
			endcase
		end
		id_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		if (commit_count == N_TOTAL && exp_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("commit count %0d does not match %0d issued", commit_count, N_TOTAL);
			abort_run;
		end
	end

endmodule

`default_nettype wire
